// ==== csr_unit.f ====
csr_pkg.sv
csr_decode.sv
csr_regfile.sv
csr_execute.sv
csr_result.sv
csr_unit.sv
tb_csr_unit.sv

// ==== Makefile ====
# Verilator build and run for the csr unit

SIM := obj_dir/Vtb_csr_unit

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

$(SIM): csr_unit.f $(shell cat csr_unit.f)
	verilator --binary --timing --assert --top-module tb_csr_unit -f csr_unit.f

clean:
	rm -rf obj_dir

// ==== tb_csr_unit.sv ====
`timescale 1ns/1ns

module tb_csr_unit;

   // one command with the response it must produce
   typedef struct packed {
      logic [31:0] instr;
      logic [31:0] pc;
      logic [31:0] rs1;
      logic        timer;
      logic        ext;
      logic        wr;
      logic [31:0] data;
      logic        redir;
      logic [31:0] target;
      logic        trap;
      logic [31:0] cause;
   } row_t;

   logic        clk = 1'b0;
   logic        rstn;
   logic        ext_intr;
   logic        timer_intr;
   logic        cmd_valid;
   logic        cmd_ready;
   logic [31:0] cmd_instr;
   logic [31:0] cmd_pc;
   logic [31:0] cmd_rs1_value;
   logic        rsp_valid;
   logic        rsp_ready = 1'b0;
   logic        rsp_rd_write;
   logic [4:0]  rsp_rd_addr;
   logic [31:0] rsp_rd_data;
   logic        rsp_redirect;
   logic [31:0] rsp_target;
   logic        rsp_trap;
   logic [31:0] rsp_cause;

   row_t        rows[$];
   logic        timer_lvl;
   logic        ext_lvl;
   int          retired = 0;
   int          sent = 0;
   int          collected = 0;
   int          errors = 0;
   int          cycles = 0;
   logic [31:0] lcg_state = 32'd84643;

   csr_unit csr_unit_inst (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // random back-pressure with ready about three cycles in four
   always @(negedge clk) begin
      lcg_state = lcg_next(lcg_state);
      rsp_ready <= (lcg_state[17:16] != 2'b00);
   end

   ////////////////////////////////////////////////////////////////////////////
   // table building
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] enc_csr(input logic [2:0] f3, input csr_pkg::csr_addr_t addr,
                                           input logic [4:0] src, input logic [4:0] rd);
      return {addr, src, f3, rd, 7'b1110011};
   endfunction

   function automatic logic [31:0] next_pc();
      return 32'h0000_2000 + rows.size() * 4;
   endfunction

   task automatic add_row(input logic [31:0] instr, input logic [31:0] rs1, input logic wr,
                          input logic [31:0] data, input logic redir, input logic [31:0] target,
                          input logic trap, input logic [31:0] cause);
      row_t r;
      r.instr  = instr;
      r.pc     = next_pc();
      r.rs1    = rs1;
      r.timer  = timer_lvl;
      r.ext    = ext_lvl;
      r.wr     = wr;
      r.data   = data;
      r.redir  = redir;
      r.target = target;
      r.trap   = trap;
      r.cause  = cause;
      rows.push_back(r);
      // trapping instructions do not retire
      if (!trap) begin
         retired++;
      end
   endtask

   task automatic add_csr(input logic [31:0] instr, input logic [31:0] rs1,
                          input logic [31:0] data);
      add_row(instr, rs1, instr[11:7] != 5'd0, data, 1'b0, 32'h0, 1'b0, 32'h0);
   endtask

   task automatic add_trap(input logic [31:0] instr, input logic [31:0] cause,
                           input logic [31:0] target);
      add_row(instr, 32'h0, 1'b0, 32'h0, 1'b1, target, 1'b1, cause);
   endtask

   task automatic build_table();
      logic [31:0] pc_save;
      timer_lvl = 1'b0;
      ext_lvl   = 1'b0;
      // read-modify-write on mscratch where x0 as source leaves it alone
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MSCRATCH, 5'd2, 5'd1), 32'h1234_5678, 32'h0);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MSCRATCH, 5'd2, 5'd3), 32'h0000_ff00, 32'h1234_5678);
      add_csr(enc_csr(3'd3, csr_pkg::CSR_MSCRATCH, 5'd2, 5'd4), 32'h1200_0078, 32'h1234_ff78);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd5), 32'hffff_ffff, 32'h0034_ff00);
      add_csr(enc_csr(3'd3, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd6), 32'hffff_ffff, 32'h0034_ff00);
      add_csr(enc_csr(3'd5, csr_pkg::CSR_MSCRATCH, 5'h15, 5'd7), 32'hdead_beef, 32'h0034_ff00);
      add_csr(enc_csr(3'd6, csr_pkg::CSR_MSCRATCH, 5'h0a, 5'd8), 32'hdead_beef, 32'h15);
      add_csr(enc_csr(3'd7, csr_pkg::CSR_MSCRATCH, 5'h03, 5'd9), 32'h0, 32'h1f);
      add_csr(enc_csr(3'd6, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd10), 32'h0, 32'h1c);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MSCRATCH, 5'd2, 5'd0), 32'h55, 32'h0);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd11), 32'h0, 32'h55);
      // write masks
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MIE, 5'd2, 5'd1), 32'hffff_ffff, 32'h0);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MIE, 5'd0, 5'd2), 32'h0, 32'h888);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MIP, 5'd2, 5'd1), 32'hffff_ffff, 32'h0);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MIP, 5'd0, 5'd2), 32'h0, 32'h8);
      add_csr(enc_csr(3'd5, csr_pkg::CSR_MIP, 5'd0, 5'd0), 32'h0, 32'h0);
      add_csr(enc_csr(3'd5, csr_pkg::CSR_MIE, 5'd0, 5'd0), 32'h0, 32'h0);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MSTATUS, 5'd2, 5'd1), 32'hffff_ffff, 32'h0);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MSTATUS, 5'd0, 5'd2), 32'h0, 32'h88);
      add_csr(enc_csr(3'd5, csr_pkg::CSR_MSTATUS, 5'd0, 5'd0), 32'h0, 32'h0);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MTVEC, 5'd2, 5'd0), 32'h400, 32'h0);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MTVEC, 5'd2, 5'd1), 32'h802, 32'h400);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MTVEC, 5'd2, 5'd1), 32'h803, 32'h400);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MTVEC, 5'd0, 5'd2), 32'h0, 32'h400);
      // illegal instructions with direct mtvec at 0x400
      pc_save = next_pc();
      add_trap(enc_csr(3'd2, 12'h7c0, 5'd0, 5'd3), 32'd2, 32'h400);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MEPC, 5'd0, 5'd4), 32'h0, pc_save);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MTVAL, 5'd0, 5'd5), 32'h0,
              enc_csr(3'd2, 12'h7c0, 5'd0, 5'd3));
      add_trap(enc_csr(3'd1, csr_pkg::CSR_MISA, 5'd2, 5'd1), 32'd2, 32'h400);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MISA, 5'd0, 5'd2), 32'h0, 32'h4000_1100);
      add_trap(enc_csr(3'd6, csr_pkg::CSR_MHARTID, 5'd1, 5'd1), 32'd2, 32'h400);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MHARTID, 5'd0, 5'd6), 32'h0, 32'h0);
      add_trap(32'h0000_4073, 32'd2, 32'h400);
      add_trap(32'h1050_0073, 32'd2, 32'h400);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MTVAL, 5'd0, 5'd7), 32'h0, 32'h1050_0073);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MCAUSE, 5'd0, 5'd8), 32'h0, 32'd2);
      // ecall, ebreak and mret with mstatus.mie set
      add_csr(enc_csr(3'd6, csr_pkg::CSR_MSTATUS, 5'd8, 5'd0), 32'h0, 32'h0);
      pc_save = next_pc();
      add_trap(32'h0000_0073, 32'd11, 32'h400);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MSTATUS, 5'd0, 5'd1), 32'h0, 32'h80);
      add_row(32'h3020_0073, 32'h0, 1'b0, 32'h0, 1'b1, pc_save, 1'b0, 32'h0);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MSTATUS, 5'd0, 5'd2), 32'h0, 32'h88);
      pc_save = next_pc();
      add_trap(32'h0010_0073, 32'd3, 32'h400);
      add_row(32'h3020_0073, 32'h0, 1'b0, 32'h0, 1'b1, pc_save, 1'b0, 32'h0);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MCAUSE, 5'd0, 5'd3), 32'h0, 32'd3);
      // timer interrupt with vectored mtvec at 0x100
      add_csr(enc_csr(3'd5, csr_pkg::CSR_MSTATUS, 5'd0, 5'd0), 32'h0, 32'h0);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MTVEC, 5'd2, 5'd0), 32'h101, 32'h0);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MIE, 5'd2, 5'd0), 32'h80, 32'h0);
      timer_lvl = 1'b1;
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MIP, 5'd0, 5'd1), 32'h0, 32'h80);
      add_csr(enc_csr(3'd6, csr_pkg::CSR_MSTATUS, 5'd8, 5'd2), 32'h0, 32'h0);
      pc_save = next_pc();
      add_trap(enc_csr(3'd1, csr_pkg::CSR_MSCRATCH, 5'd2, 5'd3), 32'h8000_0007, 32'h11c);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd4), 32'h0, 32'h55);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MCAUSE, 5'd0, 5'd5), 32'h0, 32'h8000_0007);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MEPC, 5'd0, 5'd6), 32'h0, pc_save);
      // external before software before timer
      ext_lvl = 1'b1;
      add_csr(enc_csr(3'd6, csr_pkg::CSR_MIP, 5'd8, 5'd0), 32'h0, 32'h0);
      add_csr(enc_csr(3'd1, csr_pkg::CSR_MIE, 5'd2, 5'd1), 32'h888, 32'h80);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MIP, 5'd0, 5'd2), 32'h0, 32'h888);
      add_csr(enc_csr(3'd6, csr_pkg::CSR_MSTATUS, 5'd8, 5'd0), 32'h0, 32'h0);
      add_trap(enc_csr(3'd2, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd3), 32'h8000_000b, 32'h12c);
      ext_lvl = 1'b0;
      add_csr(enc_csr(3'd6, csr_pkg::CSR_MSTATUS, 5'd8, 5'd0), 32'h0, 32'h0);
      add_trap(enc_csr(3'd2, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd3), 32'h8000_0003, 32'h10c);
      timer_lvl = 1'b0;
      add_csr(enc_csr(3'd5, csr_pkg::CSR_MIE, 5'd0, 5'd0), 32'h0, 32'h0);
      // minstret counts every non-trapping row so far
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MINSTRET, 5'd0, 5'd7), 32'h0, retired);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MINSTRETH, 5'd0, 5'd8), 32'h0, 32'h0);
      add_csr(enc_csr(3'd2, csr_pkg::CSR_MINSTRET, 5'd0, 5'd9), 32'h0, retired);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // driving and checking
   ////////////////////////////////////////////////////////////////////////////
   task automatic send_row(input int idx);
      logic taken;
      taken = 1'b0;
      // interrupt levels only change with an empty pipeline
      if (rows[idx].timer != timer_intr || rows[idx].ext != ext_intr) begin
         cmd_valid = 1'b0;
         while (collected != sent) begin
            @(negedge clk);
         end
         timer_intr = rows[idx].timer;
         ext_intr   = rows[idx].ext;
      end
      cmd_valid     = 1'b1;
      cmd_instr     = rows[idx].instr;
      cmd_pc        = rows[idx].pc;
      cmd_rs1_value = rows[idx].rs1;
      while (!taken) begin
         #1;
         taken = cmd_ready;
         @(negedge clk);
      end
      sent++;
   endtask

   task automatic report_value(input int idx, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("FAILED row %0d %s: got %h, expected %h", idx, name, got, exp);
      errors++;
   endtask

   task automatic check_response(input int idx);
      row_t r;
      r = rows[idx];
      assert (rsp_trap == r.trap)
         else report_value(idx, "rsp_trap", 32'(rsp_trap), 32'(r.trap));
      assert (rsp_redirect == r.redir)
         else report_value(idx, "rsp_redirect", 32'(rsp_redirect), 32'(r.redir));
      assert (rsp_rd_write == r.wr)
         else report_value(idx, "rsp_rd_write", 32'(rsp_rd_write), 32'(r.wr));
      if (r.trap) begin
         assert (rsp_cause == r.cause)
            else report_value(idx, "rsp_cause", rsp_cause, r.cause);
      end
      if (r.redir) begin
         assert (rsp_target == r.target)
            else report_value(idx, "rsp_target", rsp_target, r.target);
      end
      if (r.wr) begin
         assert (rsp_rd_addr == r.instr[11:7])
            else report_value(idx, "rsp_rd_addr", 32'(rsp_rd_addr), 32'(r.instr[11:7]));
         assert (rsp_rd_data == r.data)
            else report_value(idx, "rsp_rd_data", rsp_rd_data, r.data);
      end
   endtask

   // responses in command order, one per row
   always @(posedge clk) begin
      if (!rstn && rsp_valid && rsp_ready) begin
         if (collected < rows.size()) begin
            check_response(collected);
         end else begin
            $display("response arrived after the last table row was answered");
            errors++;
         end
         collected++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > rows.size() * 20) begin
         $display("timeout after %0d cycles with %0d of %0d responses", cycles, collected,
                  rows.size());
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      rstn          = 1'b1;
      ext_intr      = 1'b0;
      timer_intr    = 1'b0;
      cmd_valid     = 1'b0;
      cmd_instr     = 32'h0;
      cmd_pc        = 32'h0;
      cmd_rs1_value = 32'h0;
      build_table();
      repeat (4) @(posedge clk);
      @(negedge clk);
      rstn = 1'b0;
      for (int i = 0; i < rows.size(); i++) begin
         send_row(i);
      end
      cmd_valid = 1'b0;
      while (collected < rows.size()) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);
      $display("rows: %0d  responses: %0d  errors: %0d", rows.size(), collected, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== csr_unit.sv ====
`timescale 1ns/1ns

module csr_unit #(
   parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = '0
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      ext_intr,
   input  logic                      timer_intr,
   // command port
   input  logic                      cmd_valid,
   output logic                      cmd_ready,
   input  logic [csr_pkg::XLEN-1:0]  cmd_instr,
   input  logic [csr_pkg::XLEN-1:0]  cmd_pc,
   input  logic [csr_pkg::XLEN-1:0]  cmd_rs1_value,
   // response port
   output logic                      rsp_valid,
   input  logic                      rsp_ready,
   output logic                      rsp_rd_write,
   output logic [4:0]                rsp_rd_addr,
   output logic [csr_pkg::XLEN-1:0]  rsp_rd_data,
   output logic                      rsp_redirect,
   output logic [csr_pkg::XLEN-1:0]  rsp_target,
   output logic                      rsp_trap,
   output logic [csr_pkg::XLEN-1:0]  rsp_cause
);

   // decode to execute
   logic                     dec_valid;
   logic                     dec_ready;
   csr_pkg::csr_op_t         dec_op;
   csr_pkg::csr_addr_t       dec_addr;
   logic [4:0]               dec_rd;
   logic [4:0]               dec_uimm;
   logic [csr_pkg::XLEN-1:0] dec_instr;
   logic [csr_pkg::XLEN-1:0] dec_pc;
   logic [csr_pkg::XLEN-1:0] dec_rs1_value;

   // execute to result
   logic                     ex_valid;
   logic                     ex_ready;
   logic                     ex_rd_write;
   logic [4:0]               ex_rd_addr;
   logic [csr_pkg::XLEN-1:0] ex_rd_data;
   logic                     ex_redirect;
   logic [csr_pkg::XLEN-1:0] ex_target;
   logic                     ex_trap;
   logic [csr_pkg::XLEN-1:0] ex_cause;

   // execute and register file
   csr_pkg::csr_addr_t       rd_addr;
   logic [csr_pkg::XLEN-1:0] rd_value;
   logic                     rd_exists;
   logic                     rd_readonly;
   logic                     csr_we;
   logic [csr_pkg::XLEN-1:0] csr_wdata;
   logic                     trap_take;
   logic [csr_pkg::XLEN-1:0] trap_cause;
   logic [csr_pkg::XLEN-1:0] trap_epc;
   logic [csr_pkg::XLEN-1:0] trap_tval;
   logic                     mret_take;
   logic                     retire;
   logic [csr_pkg::XLEN-1:0] mtvec;
   logic [csr_pkg::XLEN-1:0] mepc;
   logic                     mstatus_mie;
   logic [csr_pkg::XLEN-1:0] mie;
   logic [csr_pkg::XLEN-1:0] mip;

   // port names match the wires above
   csr_decode csr_decode_inst (.*);

   csr_execute csr_execute_inst (.*);

   csr_regfile #(
      .MTVEC_RESET (MTVEC_RESET)
   ) csr_regfile_inst (.*);

   csr_result csr_result_inst (.*);

endmodule

// ==== csr_result.sv ====
`timescale 1ns/1ns

module csr_result (
   input  logic                      clk,
   input  logic                      rstn,
   // from execute
   input  logic                      ex_valid,
   output logic                      ex_ready,
   input  logic                      ex_rd_write,
   input  logic [4:0]                ex_rd_addr,
   input  logic [csr_pkg::XLEN-1:0]  ex_rd_data,
   input  logic                      ex_redirect,
   input  logic [csr_pkg::XLEN-1:0]  ex_target,
   input  logic                      ex_trap,
   input  logic [csr_pkg::XLEN-1:0]  ex_cause,
   // response port
   output logic                      rsp_valid,
   input  logic                      rsp_ready,
   output logic                      rsp_rd_write,
   output logic [4:0]                rsp_rd_addr,
   output logic [csr_pkg::XLEN-1:0]  rsp_rd_data,
   output logic                      rsp_redirect,
   output logic [csr_pkg::XLEN-1:0]  rsp_target,
   output logic                      rsp_trap,
   output logic [csr_pkg::XLEN-1:0]  rsp_cause
);

   // refill in the cycle the held entry leaves
   assign ex_ready = !rsp_valid || rsp_ready;

   always_ff @(posedge clk) begin
      if (rstn) begin
         rsp_valid <= 1'b0;
      end else if (ex_ready) begin
         rsp_valid <= ex_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid && ex_ready) begin
         rsp_rd_write <= ex_rd_write;
         rsp_rd_addr  <= ex_rd_addr;
         rsp_rd_data  <= ex_rd_data;
         rsp_redirect <= ex_redirect;
         rsp_target   <= ex_target;
         rsp_trap     <= ex_trap;
         rsp_cause    <= ex_cause;
      end
   end

endmodule

// ==== csr_execute.sv ====
`timescale 1ns/1ns

module csr_execute (
   // from decode
   input  logic                      dec_valid,
   output logic                      dec_ready,
   input  csr_pkg::csr_op_t          dec_op,
   input  csr_pkg::csr_addr_t        dec_addr,
   input  logic [4:0]                dec_rd,
   input  logic [4:0]                dec_uimm,
   input  logic [csr_pkg::XLEN-1:0]  dec_instr,
   input  logic [csr_pkg::XLEN-1:0]  dec_pc,
   input  logic [csr_pkg::XLEN-1:0]  dec_rs1_value,
   // to result
   output logic                      ex_valid,
   input  logic                      ex_ready,
   output logic                      ex_rd_write,
   output logic [4:0]                ex_rd_addr,
   output logic [csr_pkg::XLEN-1:0]  ex_rd_data,
   output logic                      ex_redirect,
   output logic [csr_pkg::XLEN-1:0]  ex_target,
   output logic                      ex_trap,
   output logic [csr_pkg::XLEN-1:0]  ex_cause,
   // register file
   output csr_pkg::csr_addr_t        rd_addr,
   input  logic [csr_pkg::XLEN-1:0]  rd_value,
   input  logic                      rd_exists,
   input  logic                      rd_readonly,
   output logic                      csr_we,
   output logic [csr_pkg::XLEN-1:0]  csr_wdata,
   output logic                      trap_take,
   output logic [csr_pkg::XLEN-1:0]  trap_cause,
   output logic [csr_pkg::XLEN-1:0]  trap_epc,
   output logic [csr_pkg::XLEN-1:0]  trap_tval,
   output logic                      mret_take,
   output logic                      retire,
   input  logic [csr_pkg::XLEN-1:0]  mtvec,
   input  logic [csr_pkg::XLEN-1:0]  mepc,
   input  logic                      mstatus_mie,
   input  logic [csr_pkg::XLEN-1:0]  mie,
   input  logic [csr_pkg::XLEN-1:0]  mip
);

   logic                     fire;
   logic                     is_csr;
   logic                     csr_writes;
   logic                     illegal;
   logic                     irq_take;
   logic                     trap;
   logic                     mret;
   logic [csr_pkg::XLEN-1:0] pending;
   logic [csr_pkg::XLEN-1:0] irq_code;
   logic [csr_pkg::XLEN-1:0] tvec_base;
   logic [csr_pkg::XLEN-1:0] trap_target;
   logic [csr_pkg::XLEN-1:0] new_value;

   // updates commit when the instruction leaves execute
   assign fire      = dec_valid && ex_ready;
   assign dec_ready = ex_ready;
   assign ex_valid  = dec_valid;
   assign rd_addr   = dec_addr;

   assign is_csr = (dec_op == csr_pkg::CSR_RW) || (dec_op == csr_pkg::CSR_RS) ||
                   (dec_op == csr_pkg::CSR_RC);
   // set/clear with a zero source field is a plain read
   assign csr_writes = (dec_op == csr_pkg::CSR_RW) || (dec_uimm != 5'd0);
   assign illegal = (dec_op == csr_pkg::SYS_ILLEGAL) ||
                    (is_csr && (!rd_exists || (csr_writes && rd_readonly)));

   ////////////////////////////////////////////////////////////////////////////
   // interrupts: external, then software, then timer
   ////////////////////////////////////////////////////////////////////////////
   assign pending  = mip & mie;
   assign irq_take = mstatus_mie && (pending != '0);
   assign irq_code = pending[csr_pkg::IRQ_EXT]  ? csr_pkg::IRQ_EXT  :
                     pending[csr_pkg::IRQ_SOFT] ? csr_pkg::IRQ_SOFT : csr_pkg::IRQ_TIMER;

   assign trap = irq_take || illegal || (dec_op == csr_pkg::SYS_ECALL) ||
                 (dec_op == csr_pkg::SYS_EBREAK);
   assign mret = !trap && (dec_op == csr_pkg::SYS_MRET);

   always_comb begin
      trap_tval = '0;
      if (irq_take) begin
         trap_cause = csr_pkg::CAUSE_IRQ_FLAG | irq_code;
      end else if (illegal) begin
         trap_cause = csr_pkg::CAUSE_ILLEGAL;
         trap_tval  = dec_instr;
      end else if (dec_op == csr_pkg::SYS_ECALL) begin
         trap_cause = csr_pkg::CAUSE_ECALL_M;
      end else begin
         trap_cause = csr_pkg::CAUSE_BREAKPOINT;
      end
   end

   // vectored mode only for interrupts
   assign tvec_base   = {mtvec[csr_pkg::XLEN-1:2], 2'b00};
   assign trap_target = (irq_take && mtvec[1:0] == 2'b01) ? tvec_base + (irq_code << 2) :
                        tvec_base;

   always_comb begin
      case (dec_op)
         csr_pkg::CSR_RW: new_value = dec_rs1_value;
         csr_pkg::CSR_RS: new_value = rd_value | dec_rs1_value;
         csr_pkg::CSR_RC: new_value = rd_value & ~dec_rs1_value;
         default:         new_value = rd_value;
      endcase
   end

   // response fields
   assign ex_trap     = trap;
   assign ex_cause    = trap ? trap_cause : '0;
   assign ex_redirect = trap || mret;
   assign ex_target   = trap ? trap_target : (mret ? mepc : '0);
   assign ex_rd_write = is_csr && !trap && (dec_rd != 5'd0);
   assign ex_rd_addr  = dec_rd;
   assign ex_rd_data  = ex_rd_write ? rd_value : '0;

   // register file controls
   assign csr_we    = fire && is_csr && !trap && csr_writes;
   assign csr_wdata = new_value;
   assign trap_take = fire && trap;
   assign trap_epc  = dec_pc;
   assign mret_take = fire && mret;
   assign retire    = fire && !trap;

endmodule

// ==== csr_regfile.sv ====
`timescale 1ns/1ns

module csr_regfile #(
   parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = '0
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      ext_intr,
   input  logic                      timer_intr,
   // read side
   input  csr_pkg::csr_addr_t        rd_addr,
   output logic [csr_pkg::XLEN-1:0]  rd_value,
   output logic                      rd_exists,
   output logic                      rd_readonly,
   // update side
   input  logic                      csr_we,
   input  logic [csr_pkg::XLEN-1:0]  csr_wdata,
   input  logic                      trap_take,
   input  logic [csr_pkg::XLEN-1:0]  trap_cause,
   input  logic [csr_pkg::XLEN-1:0]  trap_epc,
   input  logic [csr_pkg::XLEN-1:0]  trap_tval,
   input  logic                      mret_take,
   input  logic                      retire,
   // state for trap decisions
   output logic [csr_pkg::XLEN-1:0]  mtvec,
   output logic [csr_pkg::XLEN-1:0]  mepc,
   output logic                      mstatus_mie,
   output logic [csr_pkg::XLEN-1:0]  mie,
   output logic [csr_pkg::XLEN-1:0]  mip
);

   logic [csr_pkg::XLEN-1:0] mstatus_q;
   logic [csr_pkg::XLEN-1:0] mie_q;
   logic [csr_pkg::XLEN-1:0] mtvec_q;
   logic [csr_pkg::XLEN-1:0] mscratch_q;
   logic [csr_pkg::XLEN-1:0] mepc_q;
   logic [csr_pkg::XLEN-1:0] mcause_q;
   logic [csr_pkg::XLEN-1:0] mtval_q;
   logic                     msip_q;
   logic                     mtip_q;
   logic                     meip_q;
   logic [63:0]              minstret_q;

   assign mtvec       = mtvec_q;
   assign mepc        = mepc_q;
   assign mstatus_mie = mstatus_q[csr_pkg::MSTATUS_MIE];
   assign mie         = mie_q;
   assign mip = {{(csr_pkg::XLEN-12){1'b0}}, meip_q, 3'b000, mtip_q, 3'b000, msip_q, 3'b000};

   // interrupt lines follow the inputs
   always_ff @(posedge clk) begin
      if (rstn) begin
         mtip_q <= 1'b0;
         meip_q <= 1'b0;
      end else begin
         mtip_q <= timer_intr;
         meip_q <= ext_intr;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // updates: trap entry, mret, csr write
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus_q  <= '0;
         mie_q      <= '0;
         mtvec_q    <= MTVEC_RESET;
         mscratch_q <= '0;
         mepc_q     <= '0;
         mcause_q   <= '0;
         mtval_q    <= '0;
         msip_q     <= 1'b0;
      end else if (trap_take) begin
         mepc_q   <= trap_epc;
         mcause_q <= trap_cause;
         mtval_q  <= trap_tval;
         mstatus_q[csr_pkg::MSTATUS_MPIE] <= mstatus_q[csr_pkg::MSTATUS_MIE];
         mstatus_q[csr_pkg::MSTATUS_MIE]  <= 1'b0;
      end else if (mret_take) begin
         mstatus_q[csr_pkg::MSTATUS_MIE]  <= mstatus_q[csr_pkg::MSTATUS_MPIE];
         mstatus_q[csr_pkg::MSTATUS_MPIE] <= 1'b1;
      end else if (csr_we) begin
         case (rd_addr)
            csr_pkg::CSR_MSTATUS: begin
               mstatus_q <= (mstatus_q & ~csr_pkg::MSTATUS_WMASK) |
                            (csr_wdata & csr_pkg::MSTATUS_WMASK);
            end
            csr_pkg::CSR_MIE:      mie_q      <= csr_wdata & csr_pkg::MIE_WMASK;
            csr_pkg::CSR_MSCRATCH: mscratch_q <= csr_wdata;
            csr_pkg::CSR_MEPC:     mepc_q     <= csr_wdata;
            csr_pkg::CSR_MCAUSE:   mcause_q   <= csr_wdata;
            csr_pkg::CSR_MTVAL:    mtval_q    <= csr_wdata;
            csr_pkg::CSR_MIP:      msip_q     <= |(csr_wdata & csr_pkg::MIP_SW_MASK);
            csr_pkg::CSR_MTVEC: begin
               // modes 2 and 3 are reserved
               if (csr_wdata[1:0] < 2'd2) begin
                  mtvec_q <= csr_wdata;
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         minstret_q <= '0;
      end else if (retire) begin
         minstret_q <= minstret_q + 64'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read mux
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      rd_value    = '0;
      rd_exists   = 1'b1;
      rd_readonly = 1'b0;
      case (rd_addr)
         csr_pkg::CSR_MSTATUS:  rd_value = mstatus_q;
         csr_pkg::CSR_MIE:      rd_value = mie_q;
         csr_pkg::CSR_MTVEC:    rd_value = mtvec_q;
         csr_pkg::CSR_MSCRATCH: rd_value = mscratch_q;
         csr_pkg::CSR_MEPC:     rd_value = mepc_q;
         csr_pkg::CSR_MCAUSE:   rd_value = mcause_q;
         csr_pkg::CSR_MTVAL:    rd_value = mtval_q;
         csr_pkg::CSR_MIP:      rd_value = mip;
         csr_pkg::CSR_MISA: begin
            rd_value    = csr_pkg::MISA_VALUE;
            rd_readonly = 1'b1;
         end
         csr_pkg::CSR_MINSTRET: begin
            rd_value    = minstret_q[31:0];
            rd_readonly = 1'b1;
         end
         csr_pkg::CSR_MINSTRETH: begin
            rd_value    = minstret_q[63:32];
            rd_readonly = 1'b1;
         end
         // single hart, id 0
         csr_pkg::CSR_MHARTID:  rd_readonly = 1'b1;
         default:               rd_exists   = 1'b0;
      endcase
   end

endmodule

// ==== csr_decode.sv ====
`timescale 1ns/1ns

module csr_decode (
   input  logic                      clk,
   input  logic                      rstn,
   // command port
   input  logic                      cmd_valid,
   output logic                      cmd_ready,
   input  logic [csr_pkg::XLEN-1:0]  cmd_instr,
   input  logic [csr_pkg::XLEN-1:0]  cmd_pc,
   input  logic [csr_pkg::XLEN-1:0]  cmd_rs1_value,
   // to execute
   output logic                      dec_valid,
   input  logic                      dec_ready,
   output csr_pkg::csr_op_t          dec_op,
   output csr_pkg::csr_addr_t        dec_addr,
   output logic [4:0]                dec_rd,
   output logic [4:0]                dec_uimm,
   output logic [csr_pkg::XLEN-1:0]  dec_instr,
   output logic [csr_pkg::XLEN-1:0]  dec_pc,
   output logic [csr_pkg::XLEN-1:0]  dec_rs1_value
);

   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   logic [6:0]               opcode;
   logic [2:0]               funct3;
   logic [11:0]              imm;
   logic [4:0]               rs1_field;
   logic                     imm_form;
   csr_pkg::csr_op_t         op;
   logic [csr_pkg::XLEN-1:0] src;

   assign opcode    = cmd_instr[6:0];
   assign funct3    = cmd_instr[14:12];
   assign rs1_field = cmd_instr[19:15];
   assign imm       = cmd_instr[31:20];
   assign imm_form  = funct3[2];

   always_comb begin
      op = csr_pkg::SYS_ILLEGAL;
      if (opcode == OPC_SYSTEM) begin
         case (funct3)
            3'd0: begin
               case (imm)
                  12'h000: op = csr_pkg::SYS_ECALL;
                  12'h001: op = csr_pkg::SYS_EBREAK;
                  12'h302: op = csr_pkg::SYS_MRET;
                  default: op = csr_pkg::SYS_ILLEGAL;
               endcase
            end
            3'd1, 3'd5: op = csr_pkg::CSR_RW;
            3'd2, 3'd6: op = csr_pkg::CSR_RS;
            3'd3, 3'd7: op = csr_pkg::CSR_RC;
            default:    op = csr_pkg::SYS_ILLEGAL;
         endcase
      end
   end

   // immediate forms take the zero-extended rs1 field
   assign src = imm_form ? {{(csr_pkg::XLEN-5){1'b0}}, rs1_field} : cmd_rs1_value;

   ////////////////////////////////////////////////////////////////////////////
   // one-entry slot
   ////////////////////////////////////////////////////////////////////////////
   assign cmd_ready = !dec_valid || dec_ready;

   always_ff @(posedge clk) begin
      if (rstn) begin
         dec_valid <= 1'b0;
      end else if (cmd_ready) begin
         dec_valid <= cmd_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_valid && cmd_ready) begin
         dec_op        <= op;
         dec_addr      <= imm;
         dec_rd        <= cmd_instr[11:7];
         dec_uimm      <= rs1_field;
         dec_instr     <= cmd_instr;
         dec_pc        <= cmd_pc;
         dec_rs1_value <= src;
      end
   end

endmodule

// ==== csr_pkg.sv ====
package csr_pkg;

   // data and address widths
   localparam int XLEN       = 32;
   localparam int CSR_ADDR_W = 12;

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   ////////////////////////////////////////////////////////////////////////////
   // machine csr addresses
   ////////////////////////////////////////////////////////////////////////////
   localparam csr_addr_t CSR_MSTATUS   = 12'h300;
   localparam csr_addr_t CSR_MISA      = 12'h301;
   localparam csr_addr_t CSR_MIE       = 12'h304;
   localparam csr_addr_t CSR_MTVEC     = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
   localparam csr_addr_t CSR_MEPC      = 12'h341;
   localparam csr_addr_t CSR_MCAUSE    = 12'h342;
   localparam csr_addr_t CSR_MTVAL     = 12'h343;
   localparam csr_addr_t CSR_MIP       = 12'h344;
   localparam csr_addr_t CSR_MINSTRET  = 12'hb02;
   localparam csr_addr_t CSR_MINSTRETH = 12'hb82;
   localparam csr_addr_t CSR_MHARTID   = 12'hf14;

   // writable fields
   localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_0088;
   localparam logic [XLEN-1:0] MIE_WMASK     = 32'h0000_0888;
   localparam logic [XLEN-1:0] MIP_SW_MASK   = 32'h0000_0008;

   // mstatus bit positions
   localparam int MSTATUS_MIE  = 3;
   localparam int MSTATUS_MPIE = 7;

   // rv32 with i and m
   localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_1100;

   typedef enum logic [2:0] {
      CSR_NONE,
      CSR_RW,
      CSR_RS,
      CSR_RC,
      SYS_ECALL,
      SYS_EBREAK,
      SYS_MRET,
      SYS_ILLEGAL
   } csr_op_t;

   ////////////////////////////////////////////////////////////////////////////
   // trap causes
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [XLEN-1:0] CAUSE_ILLEGAL    = 32'd2;
   localparam logic [XLEN-1:0] CAUSE_BREAKPOINT = 32'd3;
   localparam logic [XLEN-1:0] CAUSE_ECALL_M    = 32'd11;

   // interrupt codes, also the mip/mie bit index
   localparam logic [XLEN-1:0] IRQ_SOFT  = 32'd3;
   localparam logic [XLEN-1:0] IRQ_TIMER = 32'd7;
   localparam logic [XLEN-1:0] IRQ_EXT   = 32'd11;

   // mcause interrupt flag
   localparam logic [XLEN-1:0] CAUSE_IRQ_FLAG = 32'h8000_0000;

endpackage
